/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := mbox_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
SIM_ARGS  := +verilator+error+limit+1000
LOG       := sim.log
PASS_MSG  := TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
hw/wb_pkg.sv
hw/mbox_pkg.sv
hw/mbox_dpram.sv
hw/mbox_enqueue.sv
hw/mbox_dequeue.sv
hw/mbox_top.sv
tests/tb_clkgen.sv
tests/mbox_dpram_props.sv
tests/mbox_checker.sv
tests/mbox_tb.sv

/* hw/mbox_dequeue.sv */
`timescale 1ns/1ps
`default_nettype none

module mbox_dequeue import wb_pkg::*, mbox_pkg::*; (
  input  wire logic    wb_clk_i,
  input  wire logic    wb_rst_i,

  output logic         snk_valid_o,
  output wb_dat_t      snk_data_o,
  input  wire logic    snk_ready_i,

  output wb_adr_t      wb_adr_o,
  output wb_dat_t      wb_dat_o,
  output logic         wb_cyc_o,
  output logic         wb_stb_o,
  output logic         wb_we_o,
  input  wire wb_dat_t wb_dat_i,
  input  wire logic    wb_ack_i
);

  deq_state_t state_q;

  // Own tail pointer and the last head seen in RAM.
  mbox_ptr_t  tail_q;
  mbox_ptr_t  head_q;

  // The output word is held as long as the state stays in PRESENT.
  assign snk_valid_o = (state_q == DEQ_PRESENT);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q <= DEQ_IDLE;
      tail_q  <= '0;
      head_q  <= '0;
    end else begin
      case (state_q)
        DEQ_IDLE: begin
          // Poll the head word only while the ring looks empty.
          if (head_q == tail_q) begin
            state_q <= DEQ_READ_HEAD;
          end else begin
            state_q <= DEQ_READ_DATA;
          end
        end
        DEQ_READ_HEAD: begin
          if (wb_ack_i) begin
            head_q  <= wb_dat_i[7:0];
            state_q <= DEQ_IDLE;
          end
        end
        DEQ_READ_DATA: begin
          if (wb_ack_i) begin
            tail_q  <= ptr_next(tail_q);
            state_q <= DEQ_WRITE_TAIL;
          end
        end
        DEQ_WRITE_TAIL: begin
          // Slot is released before the word is offered.
          // The ring then keeps all of its slots while a word waits at the output.
          if (wb_ack_i) begin
            state_q <= DEQ_PRESENT;
          end
        end
        DEQ_PRESENT: begin
          if (snk_ready_i) begin
            state_q <= DEQ_IDLE;
          end
        end
        default: begin
          state_q <= DEQ_IDLE;
        end
      endcase
    end
  end

  // Slot word captured in the ack cycle of its read.
  always_ff @(posedge wb_clk_i) begin
    if (state_q == DEQ_READ_DATA && wb_ack_i) begin
      snk_data_o <= wb_dat_i;
    end
  end

  always_comb begin
    wb_cyc_o = 1'b0;
    wb_stb_o = 1'b0;
    wb_we_o  = 1'b0;
    wb_adr_o = slot_adr(tail_q);
    wb_dat_o = ptr_word(tail_q);
    case (state_q)
      DEQ_READ_HEAD: begin
        wb_cyc_o = 1'b1;
        wb_stb_o = 1'b1;
        wb_adr_o = HEAD_ADDR;
      end
      DEQ_READ_DATA: begin
        wb_cyc_o = 1'b1;
        wb_stb_o = 1'b1;
      end
      DEQ_WRITE_TAIL: begin
        // Tail already advanced past the slot just read.
        wb_cyc_o = 1'b1;
        wb_stb_o = 1'b1;
        wb_we_o  = 1'b1;
        wb_adr_o = TAIL_ADDR;
      end
      default: begin
        wb_cyc_o = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hw/mbox_dpram.sv */
`timescale 1ns/1ps
`default_nettype none

module mbox_dpram import wb_pkg::*; #(
  parameter bit ENDIAN_SWAP = 1'b1
) (
  input  wire logic    wb_clk_i,
  input  wire logic    wb_rst_i,

  input  wire wb_adr_t wb1_adr_i,
  input  wire wb_dat_t wb1_dat_i,
  output wb_dat_t      wb1_dat_o,
  input  wire logic    wb1_cyc_i,
  input  wire logic    wb1_stb_i,
  input  wire logic    wb1_we_i,
  output logic         wb1_ack_o,

  input  wire wb_adr_t wb2_adr_i,
  input  wire wb_dat_t wb2_dat_i,
  output wb_dat_t      wb2_dat_o,
  input  wire logic    wb2_cyc_i,
  input  wire logic    wb2_stb_i,
  input  wire logic    wb2_we_i,
  output logic         wb2_ack_o
);

  wb_dat_t mem [WB_DEPTH];
  wb_dat_t rd_data_q;

  logic    wb1_rdreq;
  logic    wb1_wrreq;
  logic    wb2_rdreq;
  logic    wb2_wrreq;

  // Owner bits, 0 selects port 1.
  logic    rd_owner_q;
  logic    wr_owner_q;
  logic    rd_sel;
  logic    wr_sel;

  wb_adr_t rd_adr;
  wb_adr_t wr_adr;
  wb_dat_t wr_data;
  wb_dat_t wb2_wr_data;
  logic    wr_en;

  function automatic wb_dat_t swap_bytes(wb_dat_t d);
    return {d[7:0], d[15:8], d[23:16], d[31:24]};
  endfunction

  // Contents come up as zeros at configuration.
  initial begin
    for (int i = 0; i < WB_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // A request is ignored in its own ack cycle.
  assign wb1_rdreq = wb1_cyc_i && wb1_stb_i && !wb1_we_i && !wb1_ack_o;
  assign wb1_wrreq = wb1_cyc_i && wb1_stb_i && wb1_we_i && !wb1_ack_o;
  assign wb2_rdreq = wb2_cyc_i && wb2_stb_i && !wb2_we_i && !wb2_ack_o;
  assign wb2_wrreq = wb2_cyc_i && wb2_stb_i && wb2_we_i && !wb2_ack_o;

  // Ownership moves only when the other port asks alone.
  assign rd_sel = rd_owner_q ? !(wb1_rdreq && !wb2_rdreq) : (wb2_rdreq && !wb1_rdreq);
  assign wr_sel = wr_owner_q ? !(wb1_wrreq && !wb2_wrreq) : (wb2_wrreq && !wb1_wrreq);

  assign wb2_wr_data = ENDIAN_SWAP ? swap_bytes(wb2_dat_i) : wb2_dat_i;

  assign rd_adr  = rd_sel ? wb2_adr_i : wb1_adr_i;
  assign wr_adr  = wr_sel ? wb2_adr_i : wb1_adr_i;
  assign wr_data = wr_sel ? wb2_wr_data : wb1_dat_i;
  assign wr_en   = wr_sel ? wb2_wrreq : wb1_wrreq;

  // Read is old data on a same-address collision.
  always @(posedge wb_clk_i) begin
    if (wr_en) begin
      mem[wr_adr] <= wr_data;
    end
    rd_data_q <= mem[rd_adr];
  end

  assign wb1_dat_o = rd_data_q;
  assign wb2_dat_o = ENDIAN_SWAP ? swap_bytes(rd_data_q) : rd_data_q;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      rd_owner_q <= 1'b0;
      wr_owner_q <= 1'b0;
      wb1_ack_o  <= 1'b0;
      wb2_ack_o  <= 1'b0;
    end else begin
      rd_owner_q <= rd_sel;
      wr_owner_q <= wr_sel;
      // A port carries one access at a time, so at most one term is set.
      wb1_ack_o  <= (wb1_rdreq && !rd_sel) || (wb1_wrreq && !wr_sel);
      wb2_ack_o  <= (wb2_rdreq && rd_sel) || (wb2_wrreq && wr_sel);
    end
  end

endmodule

`default_nettype wire

/* hw/mbox_enqueue.sv */
`timescale 1ns/1ps
`default_nettype none

module mbox_enqueue import wb_pkg::*, mbox_pkg::*; (
  input  wire logic    wb_clk_i,
  input  wire logic    wb_rst_i,

  input  wire logic    src_valid_i,
  input  wire wb_dat_t src_data_i,
  output logic         src_ready_o,

  output wb_adr_t      wb_adr_o,
  output wb_dat_t      wb_dat_o,
  output logic         wb_cyc_o,
  output logic         wb_stb_o,
  output logic         wb_we_o,
  input  wire wb_dat_t wb_dat_i,
  input  wire logic    wb_ack_i
);

  enq_state_t state_q;

  // Own head pointer and the last tail seen in RAM.
  mbox_ptr_t  head_q;
  mbox_ptr_t  tail_q;

  // Word waiting to go into the ring.
  wb_dat_t    data_q;

  // One word at a time, taken only while idle.
  assign src_ready_o = (state_q == ENQ_IDLE);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q <= ENQ_IDLE;
      head_q  <= '0;
      tail_q  <= '0;
    end else begin
      case (state_q)
        ENQ_IDLE: begin
          if (src_valid_i) begin
            state_q <= ENQ_CHECK_SPACE;
          end
        end
        ENQ_CHECK_SPACE: begin
          // The cached tail only lags, so a fresh read is needed only when full.
          if (ring_full(head_q, tail_q)) begin
            state_q <= ENQ_READ_TAIL;
          end else begin
            state_q <= ENQ_WRITE_DATA;
          end
        end
        ENQ_READ_TAIL: begin
          if (wb_ack_i) begin
            tail_q  <= wb_dat_i[7:0];
            state_q <= ENQ_CHECK_SPACE;
          end
        end
        ENQ_WRITE_DATA: begin
          if (wb_ack_i) begin
            head_q  <= ptr_next(head_q);
            state_q <= ENQ_WRITE_HEAD;
          end
        end
        ENQ_WRITE_HEAD: begin
          if (wb_ack_i) begin
            state_q <= ENQ_IDLE;
          end
        end
        default: begin
          state_q <= ENQ_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (src_ready_o && src_valid_i) begin
      data_q <= src_data_i;
    end
  end

  // Bus request follows the state and holds until the ack.
  always_comb begin
    wb_cyc_o = 1'b0;
    wb_stb_o = 1'b0;
    wb_we_o  = 1'b0;
    wb_adr_o = slot_adr(head_q);
    wb_dat_o = data_q;
    case (state_q)
      ENQ_READ_TAIL: begin
        wb_cyc_o = 1'b1;
        wb_stb_o = 1'b1;
        wb_adr_o = TAIL_ADDR;
      end
      ENQ_WRITE_DATA: begin
        wb_cyc_o = 1'b1;
        wb_stb_o = 1'b1;
        wb_we_o  = 1'b1;
      end
      ENQ_WRITE_HEAD: begin
        // Head already advanced here.
        wb_cyc_o = 1'b1;
        wb_stb_o = 1'b1;
        wb_we_o  = 1'b1;
        wb_adr_o = HEAD_ADDR;
        wb_dat_o = ptr_word(head_q);
      end
      default: begin
        wb_cyc_o = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hw/mbox_pkg.sv */
`default_nettype none

package mbox_pkg;
  import wb_pkg::*;

  // Control words live below the ring.
  localparam wb_adr_t HEAD_ADDR = wb_adr_t'(0);
  localparam wb_adr_t TAIL_ADDR = wb_adr_t'(1);

  // Ring of data slots.
  localparam wb_adr_t RING_BASE  = wb_adr_t'(2);
  localparam int      RING_DEPTH = 64;
  localparam int      RING_IDX_W = $clog2(RING_DEPTH);

  // Low bits index a slot, the next bit is the wrap bit, bit 7 stays zero.
  typedef logic [7:0] mbox_ptr_t;

  typedef enum logic [2:0] {
    ENQ_IDLE,
    ENQ_CHECK_SPACE,
    ENQ_READ_TAIL,
    ENQ_WRITE_DATA,
    ENQ_WRITE_HEAD
  } enq_state_t;

  typedef enum logic [2:0] {
    DEQ_IDLE,
    DEQ_READ_HEAD,
    DEQ_READ_DATA,
    DEQ_PRESENT,
    DEQ_WRITE_TAIL
  } deq_state_t;

  // Advance a pointer, wrapping index and wrap bit together.
  function automatic mbox_ptr_t ptr_next(mbox_ptr_t p);
    mbox_ptr_t n;
    n = '0;
    n[RING_IDX_W:0] = p[RING_IDX_W:0] + 1'b1;
    return n;
  endfunction

  // Full when the writer is a whole ring ahead of the reader.
  function automatic logic ring_full(mbox_ptr_t head, mbox_ptr_t tail);
    logic [RING_IDX_W:0] used;
    used = head[RING_IDX_W:0] - tail[RING_IDX_W:0];
    return used == RING_DEPTH[RING_IDX_W:0];
  endfunction

  // RAM address of the slot a pointer refers to.
  function automatic wb_adr_t slot_adr(mbox_ptr_t p);
    return RING_BASE + wb_adr_t'(p[RING_IDX_W-1:0]);
  endfunction

  // Same byte in every lane, so either port reads the same pointer.
  function automatic wb_dat_t ptr_word(mbox_ptr_t p);
    return {4{p}};
  endfunction

endpackage

`default_nettype wire

/* hw/mbox_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mbox_top import wb_pkg::*; #(
  parameter bit ENDIAN_SWAP = 1'b1
) (
  input  wire logic    wb_clk_i,
  input  wire logic    wb_rst_i,

  input  wire logic    src_valid_i,
  input  wire wb_dat_t src_data_i,
  output logic         src_ready_o,

  output logic         snk_valid_o,
  output wb_dat_t      snk_data_o,
  input  wire logic    snk_ready_i
);

  // Port 1, enqueue side.
  wb_adr_t wb1_adr;
  wb_dat_t wb1_dat_w;
  wb_dat_t wb1_dat_r;
  logic    wb1_cyc;
  logic    wb1_stb;
  logic    wb1_we;
  logic    wb1_ack;

  // Port 2, dequeue side, opposite byte order.
  wb_adr_t wb2_adr;
  wb_dat_t wb2_dat_w;
  wb_dat_t wb2_dat_r;
  logic    wb2_cyc;
  logic    wb2_stb;
  logic    wb2_we;
  logic    wb2_ack;

  mbox_enqueue u_enqueue (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .src_valid_i (src_valid_i),
    .src_data_i  (src_data_i),
    .src_ready_o (src_ready_o),
    .wb_adr_o    (wb1_adr),
    .wb_dat_o    (wb1_dat_w),
    .wb_cyc_o    (wb1_cyc),
    .wb_stb_o    (wb1_stb),
    .wb_we_o     (wb1_we),
    .wb_dat_i    (wb1_dat_r),
    .wb_ack_i    (wb1_ack)
  );

  mbox_dpram #(
    .ENDIAN_SWAP (ENDIAN_SWAP)
  ) u_dpram (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wb1_adr_i (wb1_adr),
    .wb1_dat_i (wb1_dat_w),
    .wb1_dat_o (wb1_dat_r),
    .wb1_cyc_i (wb1_cyc),
    .wb1_stb_i (wb1_stb),
    .wb1_we_i  (wb1_we),
    .wb1_ack_o (wb1_ack),
    .wb2_adr_i (wb2_adr),
    .wb2_dat_i (wb2_dat_w),
    .wb2_dat_o (wb2_dat_r),
    .wb2_cyc_i (wb2_cyc),
    .wb2_stb_i (wb2_stb),
    .wb2_we_i  (wb2_we),
    .wb2_ack_o (wb2_ack)
  );

  mbox_dequeue u_dequeue (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .snk_valid_o (snk_valid_o),
    .snk_data_o  (snk_data_o),
    .snk_ready_i (snk_ready_i),
    .wb_adr_o    (wb2_adr),
    .wb_dat_o    (wb2_dat_w),
    .wb_cyc_o    (wb2_cyc),
    .wb_stb_o    (wb2_stb),
    .wb_we_o     (wb2_we),
    .wb_dat_i    (wb2_dat_r),
    .wb_ack_i    (wb2_ack)
  );

endmodule

`default_nettype wire

/* hw/wb_pkg.sv */
`default_nettype none

package wb_pkg;

  // Word-addressed bus, one address per 32-bit word.
  localparam int WB_ADR_W = 11;
  localparam int WB_DAT_W = 32;

  // Number of words behind the address range.
  localparam int WB_DEPTH = 2 ** WB_ADR_W;

  // Word address on either RAM port.
  typedef logic [WB_ADR_W-1:0] wb_adr_t;

  // Data word in the byte order of the port that carries it.
  typedef logic [WB_DAT_W-1:0] wb_dat_t;

endpackage

`default_nettype wire

/* tests/mbox_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module mbox_checker import wb_pkg::*; (
  input  wire logic    clk_i,
  input  wire logic    rst_i,
  input  wire logic    src_valid_i,
  input  wire logic    src_ready_i,
  input  wire wb_dat_t src_data_i,
  input  wire logic    snk_valid_i,
  input  wire logic    snk_ready_i,
  input  wire wb_dat_t snk_data_i,
  output int           error_count_o,
  output int           checked_count_o,
  output int           pending_count_o
);

  // Words in the order they must come out, already in port-2 byte order.
  wb_dat_t model_q[$];

  int      errors = 0;
  int      checked = 0;
  int      pending = 0;
  logic    hold_q = 1'b0;
  wb_dat_t held_data;
  wb_dat_t expected;

  assign error_count_o   = errors;
  assign checked_count_o = checked;
  assign pending_count_o = pending;

  // The dequeue side sees the most significant byte first.
  function automatic wb_dat_t reverse_bytes(input wb_dat_t w);
    wb_dat_t r;
    for (int b = 0; b < 4; b++) begin
      r[8*b +: 8] = w[8*(3-b) +: 8];
    end
    return r;
  endfunction

  always @(posedge clk_i) begin
    if (rst_i) begin
      hold_q = 1'b0;
    end else begin
      if (src_valid_i && src_ready_i) begin
        model_q.push_back(reverse_bytes(src_data_i));
      end

      if (snk_valid_i && snk_ready_i) begin
        if (model_q.size() == 0) begin
          $display("Output word 0x%h arrived while no word was expected.", snk_data_i);
          errors = errors + 1;
        end else begin
          expected = model_q.pop_front();
          if (snk_data_i !== expected) begin
            $display("[FAIL] snk_data_o: got 0x%h, expected 0x%h", snk_data_i, expected);
            errors = errors + 1;
          end
          checked = checked + 1;
        end
      end

      // A stalled output word must not move.
      if (hold_q) begin
        if (snk_valid_i !== 1'b1) begin
          $display("[FAIL] snk_valid_o: got 0x%h, expected 0x1", snk_valid_i);
          errors = errors + 1;
        end else if (snk_data_i !== held_data) begin
          $display("[FAIL] snk_data_o: got 0x%h, expected 0x%h", snk_data_i, held_data);
          errors = errors + 1;
        end
      end

      hold_q    = snk_valid_i && !snk_ready_i;
      held_data = snk_data_i;
      pending   = model_q.size();
    end
  end

endmodule

`default_nettype wire

/* tests/mbox_dpram_props.sv */
`timescale 1ns/1ps
`default_nettype none

module mbox_dpram_props (
  input wire logic wb_clk_i,
  input wire logic wb_rst_i,
  input wire logic wb1_cyc_i,
  input wire logic wb1_stb_i,
  input wire logic wb1_we_i,
  input wire logic wb1_ack_i,
  input wire logic wb2_cyc_i,
  input wire logic wb2_stb_i,
  input wire logic wb2_we_i,
  input wire logic wb2_ack_i
);

  int   fail_count = 0;
  logic req1;
  logic req2;
  logic same_kind;

  // A live request, masked in its own ack cycle like the RAM does.
  assign req1      = wb1_cyc_i && wb1_stb_i && !wb1_ack_i;
  assign req2      = wb2_cyc_i && wb2_stb_i && !wb2_ack_i;
  assign same_kind = req1 && req2 && (wb1_we_i == wb2_we_i);

  ack1_pulse: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb1_ack_i |=> !wb1_ack_i)
    else begin
      $error("Port 1 ack stayed high for two cycles.");
      fail_count = fail_count + 1;
    end

  ack2_pulse: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb2_ack_i |=> !wb2_ack_i)
    else begin
      $error("Port 2 ack stayed high for two cycles.");
      fail_count = fail_count + 1;
    end

  ack1_has_req: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb1_ack_i |-> $past(wb1_cyc_i && wb1_stb_i))
    else begin
      $error("Port 1 ack without a request in the cycle before.");
      fail_count = fail_count + 1;
    end

  ack2_has_req: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb2_ack_i |-> $past(wb2_cyc_i && wb2_stb_i))
    else begin
      $error("Port 2 ack without a request in the cycle before.");
      fail_count = fail_count + 1;
    end

  // Without a rival of the same kind the ack comes on the next edge.
  ack1_latency: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (req1 && !same_kind) |=> wb1_ack_i)
    else begin
      $error("Uncontested port 1 request was not acked in the next cycle.");
      fail_count = fail_count + 1;
    end

  ack2_latency: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (req2 && !same_kind) |=> wb2_ack_i)
    else begin
      $error("Uncontested port 2 request was not acked in the next cycle.");
      fail_count = fail_count + 1;
    end

endmodule

bind mbox_dpram mbox_dpram_props u_props (
  .wb_clk_i  (wb_clk_i),
  .wb_rst_i  (wb_rst_i),
  .wb1_cyc_i (wb1_cyc_i),
  .wb1_stb_i (wb1_stb_i),
  .wb1_we_i  (wb1_we_i),
  .wb1_ack_i (wb1_ack_o),
  .wb2_cyc_i (wb2_cyc_i),
  .wb2_stb_i (wb2_stb_i),
  .wb2_we_i  (wb2_we_i),
  .wb2_ack_i (wb2_ack_o)
);

`default_nettype wire

/* tests/mbox_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mbox_tb import wb_pkg::*; ();

  localparam int SEED_INIT      = 74843;
  localparam int N_RANDOM_WORDS = 300;
  localparam int N_FREE_WORDS   = 400;
  localparam int CAPACITY       = 66;
  localparam int LOW_RUN        = 200;
  localparam int IDLE_CYCLES    = 100;
  localparam int RESET_LIMIT    = 100;
  localparam int TRAFFIC_LIMIT  = 20000;
  localparam int FILL_LIMIT     = 3000;
  localparam int DRAIN_LIMIT    = 5000;

  logic    wb_clk_i;
  logic    wb_rst_i;
  logic    src_valid_i;
  wb_dat_t src_data_i;
  logic    src_ready_o;
  logic    snk_valid_o;
  wb_dat_t snk_data_o;
  logic    snk_ready_i;

  int      seed;
  int      sent_total;
  bit      src_fire;
  bit      timed_out;
  int      tb_errors;
  int      chk_errors;
  int      checked_words;
  int      pending_words;
  int      assert_fails;

  tb_clkgen u_clkgen (
    .clk_o (wb_clk_i),
    .rst_o (wb_rst_i)
  );

  mbox_top #(
    .ENDIAN_SWAP (1'b1)
  ) u_mbox_top (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .src_valid_i (src_valid_i),
    .src_data_i  (src_data_i),
    .src_ready_o (src_ready_o),
    .snk_valid_o (snk_valid_o),
    .snk_data_o  (snk_data_o),
    .snk_ready_i (snk_ready_i)
  );

  mbox_checker u_checker (
    .clk_i           (wb_clk_i),
    .rst_i           (wb_rst_i),
    .src_valid_i     (src_valid_i),
    .src_ready_i     (src_ready_o),
    .src_data_i      (src_data_i),
    .snk_valid_i     (snk_valid_o),
    .snk_ready_i     (snk_ready_i),
    .snk_data_i      (snk_data_o),
    .error_count_o   (chk_errors),
    .checked_count_o (checked_words),
    .pending_count_o (pending_words)
  );

  function automatic bit chance(input int pct);
    return ({$random(seed)} % 100) < pct;
  endfunction

  // One falling edge of stimulus. An offered word stays until it is taken.
  task automatic drive_cycle(input int target, input int valid_pct, input int ready_pct);
    @(negedge wb_clk_i);
    if (src_fire) begin
      sent_total++;
    end
    if (!src_valid_i || src_fire) begin
      src_valid_i = (sent_total < target) && chance(valid_pct);
      src_data_i  = $random(seed);
    end
    snk_ready_i = chance(ready_pct);
    src_fire    = src_valid_i && src_ready_o;
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    @(negedge wb_clk_i);
    while (wb_rst_i && cycles < RESET_LIMIT) begin
      @(negedge wb_clk_i);
      cycles++;
    end
    if (wb_rst_i) begin
      $display("Timeout: reset was never released.");
      timed_out = 1'b1;
    end
  endtask

  task automatic check_reset_values();
    if (src_ready_o !== 1'b1) begin
      $display("[FAIL] src_ready_o: got 0x%h, expected 0x1", src_ready_o);
      tb_errors++;
    end
    if (snk_valid_o !== 1'b0) begin
      $display("[FAIL] snk_valid_o: got 0x%h, expected 0x0", snk_valid_o);
      tb_errors++;
    end
  endtask

  task automatic run_random(input int n_words, input int valid_pct, input int ready_pct);
    int target;
    int cycles;
    target = sent_total + n_words;
    cycles = 0;
    while (sent_total < target && cycles < TRAFFIC_LIMIT) begin
      drive_cycle(target, valid_pct, ready_pct);
      cycles++;
    end
    if (sent_total < target) begin
      $display("Timeout: only %0d of %0d words were accepted.", sent_total, target);
      timed_out = 1'b1;
    end
  endtask

  task automatic drain_output();
    int cycles;
    cycles = 0;
    while (pending_words != 0 && cycles < DRAIN_LIMIT) begin
      drive_cycle(sent_total, 0, 100);
      cycles++;
    end
    if (pending_words != 0) begin
      $display("Timeout: %0d words never left the mailbox.", pending_words);
      timed_out = 1'b1;
    end
  endtask

  // Once the mailbox is empty no further word may appear at the output.
  task automatic check_idle_output();
    int cycles;
    cycles = 0;
    while (cycles < IDLE_CYCLES) begin
      drive_cycle(sent_total, 0, 100);
      cycles++;
      if (snk_valid_o !== 1'b0) begin
        $display("[FAIL] snk_valid_o: got 0x%h, expected 0x0", snk_valid_o);
        tb_errors++;
      end
    end
  endtask

  // With the sink stalled one word waits at the output and one in the enqueue.
  task automatic check_backpressure();
    int start;
    int low_run;
    int cycles;
    start   = sent_total;
    low_run = 0;
    cycles  = 0;
    while (low_run < LOW_RUN && cycles < FILL_LIMIT) begin
      drive_cycle(start + 1000, 100, 0);
      cycles++;
      if (src_ready_o) begin
        low_run = 0;
      end else begin
        low_run++;
      end
    end
    if (low_run < LOW_RUN) begin
      $display("Timeout: src_ready_o never stayed low with the output stalled.");
      timed_out = 1'b1;
    end else if (sent_total - start != CAPACITY) begin
      $display("[FAIL] words accepted with snk_ready_i low: got 0x%h, expected 0x%h",
               sent_total - start, CAPACITY);
      tb_errors++;
    end
    // The word still on offer is withdrawn.
    @(negedge wb_clk_i);
    if (src_fire) begin
      sent_total++;
    end
    src_valid_i = 1'b0;
    src_fire    = 1'b0;
  endtask

  initial begin
    src_valid_i = 1'b0;
    src_data_i  = '0;
    snk_ready_i = 1'b0;
    seed        = SEED_INIT;
    sent_total  = 0;
    src_fire    = 1'b0;
    timed_out   = 1'b0;
    tb_errors   = 0;

    wait_reset_release();
    if (!timed_out) begin
      check_reset_values();
      run_random(N_RANDOM_WORDS, 70, 60);
    end
    if (!timed_out) begin
      drain_output();
    end
    if (!timed_out) begin
      check_backpressure();
    end
    if (!timed_out) begin
      drain_output();
    end
    if (!timed_out) begin
      run_random(N_FREE_WORDS, 100, 100);
    end
    if (!timed_out) begin
      drain_output();
    end
    if (!timed_out) begin
      check_idle_output();
    end

    assert_fails = u_mbox_top.u_dpram.u_props.fail_count;
    $display("Summary: %0d sent, %0d compared, errors %0d checker, %0d tb, %0d assertion",
             sent_total, checked_words, chk_errors, tb_errors, assert_fails);
    if (!timed_out && chk_errors == 0 && tb_errors == 0 && assert_fails == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int HALF_PERIOD  = 5,
  parameter int RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

  always #HALF_PERIOD clk_o = ~clk_o;

endmodule

`default_nettype wire
